//--- src/zx_host_pkg.sv
`default_nettype none

package zx_host_pkg;

	// ========================================================================
	// Bus and memory widths
	// ========================================================================

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;

	// Physical 16 KB bank: RAM 0..7, then ROMs from ROM_BANK_BASE
	typedef logic [3:0]  bank_t;

	localparam int PHYS_ADDR_W = 18;
	typedef logic [PHYS_ADDR_W-1:0] phys_addr_t;

	localparam bank_t ROM_BANK_BASE = 4'd8;

	// ========================================================================
	// Machine models
	// ========================================================================

	typedef logic [1:0] model_t;

	localparam model_t MODEL_48    = 2'd0;
	localparam model_t MODEL_128   = 2'd1;
	localparam model_t MODEL_PLUS3 = 2'd2;

	// ========================================================================
	// Port bit positions
	// ========================================================================

	// Port FE write fields
	localparam int FE_BORDER_LSB = 0;
	localparam int FE_MIC_BIT    = 3;
	localparam int FE_EAR_BIT    = 4;

	// Port 7FFD
	localparam int P7FFD_ROM_BIT  = 4;
	localparam int P7FFD_LOCK_BIT = 5;

	// Audio DAC input width
	localparam int DAC_W_DEFAULT = 9;

endpackage

`default_nettype wire

//--- src/zx_io_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded CPU access, shared by all I/O peripherals
interface zx_io_if;

	zx_host_pkg::cpu_addr_t addr;
	zx_host_pkg::byte_t     wdata;

	// One-cycle strobes, high in the cycle the I/O access completes
	logic io_wr;
	logic io_rd;

	modport bus_frontend (
		output addr,
		output wdata,
		output io_wr,
		output io_rd
	);

	modport peripheral (
		input addr,
		input wdata,
		input io_wr,
		input io_rd
	);

endinterface

`default_nettype wire

//--- src/bus_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module bus_frontend (
	input  wire                      clk_sys,
	input  wire                      reset,

	// Wishbone classic slave
	input  zx_host_pkg::cpu_addr_t   wb_adr,
	input  zx_host_pkg::byte_t       wb_dat_i,
	output zx_host_pkg::byte_t       wb_dat_o,
	input  wire                      wb_we,
	input  wire                      wb_stb,
	input  wire                      wb_cyc,
	output logic                     wb_ack,
	input  wire                      wb_tga_io,

	// External memory port
	output zx_host_pkg::phys_addr_t  mem_addr,
	output zx_host_pkg::byte_t       mem_wdata,
	output logic                     mem_rd,
	output logic                     mem_we,
	input  zx_host_pkg::byte_t       mem_rdata,
	input  wire                      mem_ready,

	zx_io_if.bus_frontend            io,

	input  zx_host_pkg::phys_addr_t  phys_addr,
	input  wire                      write_allowed,
	input  zx_host_pkg::byte_t       io_rdata,
	input  wire                      io_hit
);

	typedef enum logic [1:0] {
		IDLE,
		MEM_REQ,
		IO_DONE,
		ACK
	} state_t;

	state_t state;
	zx_host_pkg::byte_t rdata_q;

	// ========================================================================
	// Access FSM
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (wb_cyc && wb_stb) begin
						if (wb_tga_io)
							state <= IO_DONE;
						// Write into ROM: skip the memory, ack anyway
						else if (wb_we && !write_allowed)
							state <= ACK;
						else
							state <= MEM_REQ;
					end
				end
				MEM_REQ: begin
					if (mem_ready)
						state <= ACK;
				end
				IO_DONE, ACK: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Memory read data, held for the ack cycle
	always_ff @(posedge clk_sys) begin
		if (state == MEM_REQ && mem_ready && !wb_we)
			rdata_q <= mem_rdata;
	end

	// ========================================================================
	// Memory port
	// ========================================================================

	// Address comes straight from the pager, stable while wb_adr is held
	assign mem_addr  = phys_addr;
	assign mem_wdata = wb_dat_i;
	assign mem_rd    = (state == MEM_REQ) && !wb_we;
	assign mem_we    = (state == MEM_REQ) && wb_we && write_allowed;

	// ========================================================================
	// I/O strobes and Wishbone response
	// ========================================================================

	assign io.addr  = wb_adr;
	assign io.wdata = wb_dat_i;
	assign io.io_wr = (state == IO_DONE) && wb_we;
	assign io.io_rd = (state == IO_DONE) && !wb_we;

	assign wb_ack = (state == ACK) || (state == IO_DONE);

	// Unclaimed I/O reads float high as on the real bus
	assign wb_dat_o = (state == IO_DONE) ? (io_hit ? io_rdata : 8'hFF) : rdata_q;

endmodule

`default_nettype wire

//--- src/memory_pager.sv
`timescale 1ns/1ps
`default_nettype none

module memory_pager (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  zx_host_pkg::model_t      model,
	zx_io_if.peripheral              io,
	output zx_host_pkg::phys_addr_t  phys_addr,
	output logic                     write_allowed
);

	zx_host_pkg::model_t model_q;
	zx_host_pkg::byte_t  p7ffd;
	zx_host_pkg::byte_t  p1ffd;

	logic       is_48;
	logic       is_plus3;
	logic       locked;
	logic       wr_7ffd;
	logic       wr_1ffd;
	logic       special;
	logic [1:0] special_cfg;
	logic [1:0] seg;
	logic [1:0] rom_sel;
	logic       rom_mapped;

	zx_host_pkg::bank_t bank;

	// ========================================================================
	// Paging registers
	// ========================================================================

	assign is_48    = (model_q == zx_host_pkg::MODEL_48);
	// Code 3 falls through to 128K behaviour
	assign is_plus3 = (model_q == zx_host_pkg::MODEL_PLUS3);
	assign locked   = p7ffd[zx_host_pkg::P7FFD_LOCK_BIT];

	// 7FFD: A15=0, A1=0, and A14=1 on +3
	assign wr_7ffd = io.io_wr && !io.addr[15] && !io.addr[1]
		&& (io.addr[14] || !is_plus3) && !is_48 && !locked;

	// 1FFD: +3 only, A15..A12=0001, A1=0
	assign wr_1ffd = io.io_wr && is_plus3 && (io.addr[15:12] == 4'b0001)
		&& !io.addr[1] && !locked;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= model;
			p7ffd   <= '0;
			p1ffd   <= '0;
		end else begin
			if (wr_7ffd)
				p7ffd <= io.wdata;
			if (wr_1ffd)
				p1ffd <= io.wdata;
		end
	end

	// ========================================================================
	// Address translation
	// ========================================================================

	assign seg         = io.addr[15:14];
	assign special     = is_plus3 && p1ffd[0];
	assign special_cfg = p1ffd[2:1];

	// ROM number within the ROM area
	// 48K never writes 7FFD, so the 128K map gives ROM 0 and bank 0 there
	always_comb begin
		if (is_plus3)
			rom_sel = {p1ffd[2], p7ffd[zx_host_pkg::P7FFD_ROM_BIT]};
		else
			rom_sel = {1'b0, p7ffd[zx_host_pkg::P7FFD_ROM_BIT]};
	end

	always_comb begin
		rom_mapped = 1'b0;
		bank       = '0;
		if (special) begin
			// +3 all-RAM configurations
			case (seg)
				2'd0: bank = (special_cfg == 2'd0) ? 4'd0 : 4'd4;
				2'd1: begin
					if (special_cfg == 2'd0)
						bank = 4'd1;
					else if (special_cfg == 2'd3)
						bank = 4'd7;
					else
						bank = 4'd5;
				end
				2'd2: bank = (special_cfg == 2'd0) ? 4'd2 : 4'd6;
				default: bank = (special_cfg == 2'd1) ? 4'd7 : 4'd3;
			endcase
		end else begin
			case (seg)
				2'd0: begin
					bank       = zx_host_pkg::ROM_BANK_BASE + {2'b00, rom_sel};
					rom_mapped = 1'b1;
				end
				2'd1: bank = 4'd5;
				2'd2: bank = 4'd2;
				default: bank = {1'b0, p7ffd[2:0]};
			endcase
		end
	end

	assign phys_addr     = {bank, io.addr[13:0]};
	assign write_allowed = !rom_mapped;

endmodule

`default_nettype wire

//--- src/ula_port.sv
`timescale 1ns/1ps
`default_nettype none

module ula_port (
	input  wire                 clk_sys,
	input  wire                 reset,
	zx_io_if.peripheral         io,
	input  wire  [4:0]          key_data,
	input  wire                 tape_in,
	output logic [2:0]          border,
	output logic                ear,
	output logic                mic,
	output zx_host_pkg::byte_t  io_rdata,
	output logic                io_hit
);

	logic fe_sel;

	// ULA answers on every even port address
	assign fe_sel = !io.addr[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= '0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (io.io_wr && fe_sel) begin
			border <= io.wdata[zx_host_pkg::FE_BORDER_LSB +: 3];
			mic    <= io.wdata[zx_host_pkg::FE_MIC_BIT];
			ear    <= io.wdata[zx_host_pkg::FE_EAR_BIT];
		end
	end

	// Keyboard row plus tape input, unused bits high
	assign io_rdata = {1'b1, tape_in, 1'b1, key_data};
	assign io_hit   = io.io_rd && fe_sel;

endmodule

`default_nettype wire

//--- src/sigma_delta_dac.sv
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_dac #(
	parameter int DAC_W = zx_host_pkg::DAC_W_DEFAULT
) (
	input  wire   clk_sys,
	input  wire   reset,
	input  wire   ear,
	input  wire   mic,
	input  wire   tape_in,
	output logic  audio
);

	logic [DAC_W-1:0] level;
	logic [DAC_W-1:0] acc;
	logic [DAC_W:0]   sum;

	// Weights of 1/4, 1/8 and 1/16 of full scale
	assign level = {1'b0, ear, mic, tape_in, {(DAC_W-4){1'b0}}};

	assign sum = {1'b0, acc} + {1'b0, level};

	// First-order modulator, the carry is the bitstream
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc   <= '0;
			audio <= 1'b0;
		end else begin
			acc   <= sum[DAC_W-1:0];
			audio <= sum[DAC_W];
		end
	end

endmodule

`default_nettype wire

//--- src/zx_host.sv
`timescale 1ns/1ps
`default_nettype none

module zx_host #(
	parameter int DAC_W = zx_host_pkg::DAC_W_DEFAULT
) (
	input  wire                      clk_sys,
	input  wire                      reset,

	// ========================================================================
	// Wishbone slave, CPU side
	// ========================================================================
	input  zx_host_pkg::cpu_addr_t   wb_adr,
	input  zx_host_pkg::byte_t       wb_dat_i,
	output zx_host_pkg::byte_t       wb_dat_o,
	input  wire                      wb_we,
	input  wire                      wb_stb,
	input  wire                      wb_cyc,
	output logic                     wb_ack,
	input  wire                      wb_tga_io,

	// ========================================================================
	// External memory
	// ========================================================================
	output zx_host_pkg::phys_addr_t  mem_addr,
	output zx_host_pkg::byte_t       mem_wdata,
	output logic                     mem_rd,
	output logic                     mem_we,
	input  zx_host_pkg::byte_t       mem_rdata,
	input  wire                      mem_ready,

	input  zx_host_pkg::model_t      model,
	input  wire  [4:0]               key_data,
	input  wire                      tape_in,
	output logic [2:0]               border,
	output logic                     audio
);

	zx_host_pkg::phys_addr_t phys_addr;
	zx_host_pkg::byte_t      io_rdata;
	logic                    write_allowed;
	logic                    io_hit;
	logic                    ear;
	logic                    mic;

	zx_io_if io ();

	bus_frontend i_bus_frontend (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.wb_adr        (wb_adr),
		.wb_dat_i      (wb_dat_i),
		.wb_dat_o      (wb_dat_o),
		.wb_we         (wb_we),
		.wb_stb        (wb_stb),
		.wb_cyc        (wb_cyc),
		.wb_ack        (wb_ack),
		.wb_tga_io     (wb_tga_io),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_rd        (mem_rd),
		.mem_we        (mem_we),
		.mem_rdata     (mem_rdata),
		.mem_ready     (mem_ready),
		.io            (io.bus_frontend),
		.phys_addr     (phys_addr),
		.write_allowed (write_allowed),
		.io_rdata      (io_rdata),
		.io_hit        (io_hit)
	);

	memory_pager i_memory_pager (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.model         (model),
		.io            (io.peripheral),
		.phys_addr     (phys_addr),
		.write_allowed (write_allowed)
	);

	ula_port i_ula_port (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.io       (io.peripheral),
		.key_data (key_data),
		.tape_in  (tape_in),
		.border   (border),
		.ear      (ear),
		.mic      (mic),
		.io_rdata (io_rdata),
		.io_hit   (io_hit)
	);

	sigma_delta_dac #(
		.DAC_W (DAC_W)
	) i_sigma_delta_dac (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ear     (ear),
		.mic     (mic),
		.tape_in (tape_in),
		.audio   (audio)
	);

endmodule

`default_nettype wire

//--- tb/zx_host_checker.sv
`timescale 1ns/1ps
`default_nettype none

module zx_host_checker (
	input wire clk_sys,
	input wire reset,
	input wire wb_stb,
	input wire wb_cyc,
	input wire wb_ack,
	input wire mem_rd,
	input wire mem_we,
	input wire [zx_host_pkg::PHYS_ADDR_W-1:0] mem_addr,
	input wire write_allowed
);

	int unsigned fail_count = 0;

	// ========================================================================
	// Wishbone handshake
	// ========================================================================

	ack_needs_stb: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |-> wb_stb && wb_cyc)
	else begin
		fail_count++;
		$error("wb_ack raised without an active strobe");
	end

	ack_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |=> !wb_ack)
	else begin
		fail_count++;
		$error("wb_ack held for more than one cycle");
	end

	// Bus quiet in the cycle after reset
	quiet_after_reset: assert property (@(posedge clk_sys)
		reset |=> !wb_ack && !mem_rd && !mem_we)
	else begin
		fail_count++;
		$error("wb_ack or a memory strobe high after reset");
	end

	// ROM banks sit at the top of the physical space
	rom_write_blocked: assert property (@(posedge clk_sys) disable iff (reset)
		mem_we |-> write_allowed && !mem_addr[zx_host_pkg::PHYS_ADDR_W-1])
	else begin
		fail_count++;
		$error("mem_we raised on a ROM bank or while a ROM is mapped");
	end

endmodule

bind zx_host zx_host_checker i_zx_host_checker (
	.clk_sys       (clk_sys),
	.reset         (reset),
	.wb_stb        (wb_stb),
	.wb_cyc        (wb_cyc),
	.wb_ack        (wb_ack),
	.mem_rd        (mem_rd),
	.mem_we        (mem_we),
	.mem_addr      (mem_addr),
	.write_allowed (write_allowed)
);

`default_nettype wire

//--- tb/tb_zx_host.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zx_host;

	// Under 200 accesses of at most 8 cycles plus about 1100 audio cycles
	localparam int MAX_CYCLES = 20000;

	logic                    clk_sys;
	logic                    reset;
	zx_host_pkg::cpu_addr_t  wb_adr;
	zx_host_pkg::byte_t      wb_dat_i;
	zx_host_pkg::byte_t      wb_dat_o;
	logic                    wb_we;
	logic                    wb_stb;
	logic                    wb_cyc;
	logic                    wb_ack;
	logic                    wb_tga_io;
	zx_host_pkg::phys_addr_t mem_addr;
	zx_host_pkg::byte_t      mem_wdata;
	logic                    mem_rd;
	logic                    mem_we;
	zx_host_pkg::byte_t      mem_rdata;
	logic                    mem_ready;
	zx_host_pkg::model_t     model;
	logic [4:0]              key_data;
	logic                    tape_in;
	logic [2:0]              border;
	logic                    audio;

	zx_host_pkg::byte_t mem [0:(1 << zx_host_pkg::PHYS_ADDR_W) - 1];
	logic [1:0]         wait_cnt = 2'd0;
	integer             seed = 98676;
	int                 errors = 0;
	int                 cycles = 0;

	// Expected state of the paging ports
	zx_host_pkg::byte_t p7ffd;
	zx_host_pkg::byte_t p1ffd;

	zx_host i_zx_host (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// Memory model, ready after 0 to 3 extra cycles
	// ========================================================================

	always @(posedge clk_sys) begin
		if (reset || !(mem_rd || mem_we)) begin
			mem_ready <= 1'b0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0;
			wait_cnt  <= 2'($random(seed));
		end else if (wait_cnt != 2'd0) begin
			wait_cnt <= wait_cnt - 2'd1;
		end else begin
			mem_ready <= 1'b1;
			mem_rdata <= mem[mem_addr];
			if (mem_we)
				mem[mem_addr] <= mem_wdata;
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	// Bank number in the high nibble, folded offset in the low one
	function automatic zx_host_pkg::byte_t fill_byte(input zx_host_pkg::phys_addr_t pa);
		return {pa[17:14], pa[3:0] ^ pa[7:4] ^ pa[11:8] ^ {2'b00, pa[13:12]}};
	endfunction

	// Bank behind a CPU segment, segment 0 in the low nibble of the map
	function automatic zx_host_pkg::bank_t exp_bank(input int seg);
		logic [15:0] map;
		logic        plus3;
		plus3 = (model == zx_host_pkg::MODEL_PLUS3);
		map   = {1'b0, p7ffd[2:0], 8'h25, 2'b10, plus3 & p1ffd[2],
			p7ffd[zx_host_pkg::P7FFD_ROM_BIT]};
		if (model == zx_host_pkg::MODEL_48)
			map = 16'h0258;
		else if (plus3 && p1ffd[0])
			case (p1ffd[2:1])
				2'd0: map = 16'h3210;
				2'd1: map = 16'h7654;
				2'd2: map = 16'h3654;
				default: map = 16'h3674;
			endcase
		return map[seg * 4 +: 4];
	endfunction

	task automatic check_value(input string name, input int expected, input int actual,
		input int tol);
		assert (actual >= expected - tol && actual <= expected + tol)
		else begin
			errors++;
			$error("Error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// ========================================================================
	// Wishbone master
	// ========================================================================

	task automatic bus_access(input logic io, input logic we, input zx_host_pkg::cpu_addr_t adr,
		input zx_host_pkg::byte_t data, output zx_host_pkg::byte_t rdata);
		@(posedge clk_sys);
		wb_cyc    <= 1'b1;
		wb_stb    <= 1'b1;
		wb_tga_io <= io;
		wb_we     <= we;
		wb_adr    <= adr;
		wb_dat_i  <= data;
		do begin
			@(negedge clk_sys);
		end while (!wb_ack);
		rdata = wb_dat_o;
		@(posedge clk_sys);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	// I/O write that also tracks 7FFD and 1FFD
	task automatic page_write(input zx_host_pkg::cpu_addr_t adr, input zx_host_pkg::byte_t data);
		zx_host_pkg::byte_t unused;
		logic               plus3;
		plus3 = (model == zx_host_pkg::MODEL_PLUS3);
		bus_access(1'b1, 1'b1, adr, data, unused);
		if (model != zx_host_pkg::MODEL_48 && !p7ffd[zx_host_pkg::P7FFD_LOCK_BIT] && !adr[1]) begin
			if (!adr[15] && (adr[14] || !plus3))
				p7ffd = data;
			else if (plus3 && adr[15:12] == 4'b0001)
				p1ffd = data;
		end
	endtask

	// Offsets stay above 2000h, clear of the write tests
	task automatic read_segments(input string name);
		zx_host_pkg::byte_t rdata;
		logic [13:0]        offset;
		for (int seg = 0; seg < 4; seg++) begin
			offset = 14'h2000 | 14'($random(seed));
			bus_access(1'b0, 1'b0, {seg[1:0], offset}, 8'h00, rdata);
			check_value(name, fill_byte({exp_bank(seg), offset}), rdata, 0);
		end
	endtask

	task automatic apply_reset(input zx_host_pkg::model_t m);
		@(posedge clk_sys);
		model <= m;
		reset <= 1'b1;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		p7ffd = 8'h00;
		p1ffd = 8'h00;
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial begin
		zx_host_pkg::byte_t rdata;
		zx_host_pkg::byte_t data;
		int                 ones;
		reset     = 1'b1;
		wb_adr    = '0;
		wb_dat_i  = '0;
		wb_we     = 1'b0;
		wb_stb    = 1'b0;
		wb_cyc    = 1'b0;
		wb_tga_io = 1'b0;
		mem_rdata = '0;
		mem_ready = 1'b0;
		model     = zx_host_pkg::MODEL_128;
		key_data  = '0;
		tape_in   = 1'b0;
		for (int a = 0; a < (1 << zx_host_pkg::PHYS_ADDR_W); a++)
			mem[a] = fill_byte(a[17:0]);

		apply_reset(zx_host_pkg::MODEL_128);
		read_segments("reset map 128k");
		repeat (8) begin
			page_write(16'h7FFD, 8'($random(seed)) & 8'hDF);
			read_segments("paging 128k");
		end
		page_write(16'h7FFD, 8'h23);
		page_write(16'h7FFD, 8'h15);
		read_segments("lock 128k");
		for (int seg = 0; seg < 4; seg++) begin
			bus_access(1'b0, 1'b1, {seg[1:0], 14'h0123}, 8'hA0 + 8'(seg), rdata);
			bus_access(1'b0, 1'b0, {seg[1:0], 14'h0123}, 8'h00, rdata);
			data = (seg == 0) ? fill_byte({exp_bank(0), 14'h0123}) : 8'hA0 + 8'(seg);
			check_value("rom protection", data, rdata, 0);
		end
		repeat (8) read_segments("back-pressure");

		// Port FE, then an odd port that nothing claims
		repeat (4) begin
			data = 8'($random(seed));
			@(posedge clk_sys);
			key_data <= 5'($random(seed));
			tape_in  <= 1'($random(seed));
			bus_access(1'b1, 1'b1, {8'($random(seed)), 8'hFE}, data, rdata);
			@(negedge clk_sys);
			check_value("fe border", data[2:0], border, 0);
			bus_access(1'b1, 1'b0, 16'h00FE, 8'h00, rdata);
			check_value("fe read", {1'b1, tape_in, 1'b1, key_data}, rdata, 0);
			bus_access(1'b1, 1'b0, 16'($random(seed)) | 16'h0001, 8'h00, rdata);
			check_value("unclaimed io read", 8'hFF, rdata, 0);
		end

		// Ones over one full accumulator period
		for (int i = 0; i < 2; i++) begin
			@(posedge clk_sys);
			tape_in <= i[0];
			bus_access(1'b1, 1'b1, 16'h00FE, i[0] ? 8'h18 : 8'h10, rdata);
			ones = 0;
			repeat (512) begin
				@(negedge clk_sys);
				ones += audio;
			end
			check_value("audio level", i[0] ? 128 + 64 + 32 : 128, ones, 1);
		end

		apply_reset(zx_host_pkg::MODEL_PLUS3);
		read_segments("reset map plus3");
		for (int cfg = 0; cfg < 4; cfg++) begin
			page_write(16'h1FFD, {5'b00000, cfg[1:0], 1'b1});
			read_segments("special plus3");
		end
		for (int rom = 0; rom < 4; rom++) begin
			page_write(16'h1FFD, {5'b00000, rom[1], 2'b00});
			page_write(16'h7FFD, {3'b000, rom[0], 2'b00, rom[1:0]});
			read_segments("rom select plus3");
		end
		// A14 low misses 7FFD on +3
		page_write(16'h3FFD, 8'h07);
		read_segments("decode plus3");

		apply_reset(zx_host_pkg::MODEL_48);
		page_write(16'h7FFD, 8'h17);
		read_segments("48k ignores 7ffd");

		$display("Value errors: %0d, checker assertion failures: %0d", errors,
			i_zx_host.i_zx_host_checker.fail_count);
		if (errors == 0 && i_zx_host.i_zx_host_checker.fail_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
src/zx_host_pkg.sv
src/zx_io_if.sv
src/bus_frontend.sv
src/memory_pager.sv
src/ula_port.sv
src/sigma_delta_dac.sv
src/zx_host.sv
tb/zx_host_checker.sv
tb/tb_zx_host.sv

//--- Bender.yml
package:
  name: zx_host

sources:
  - src/zx_host_pkg.sv
  - src/zx_io_if.sv
  - src/bus_frontend.sv
  - src/memory_pager.sv
  - src/ula_port.sv
  - src/sigma_delta_dac.sv
  - src/zx_host.sv
  - target: test
    files:
      - tb/zx_host_checker.sv
      - tb/tb_zx_host.sv
